//--- all.f
logic/frontend_pkg.sv
logic/fetch_pc.sv
logic/inst_queue.sv
logic/issue_pair.sv
logic/frontend_top.sv
testbench/tb_clock.sv
testbench/frontend_asserts.sv
testbench/frontend_tb.sv

//--- logic/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               redirect_valid,
    input  logic [frontend_pkg::xlen-1:0]      redirect_pc,
    input  logic                               fetch_stall_req,
    output logic [frontend_pkg::xlen-1:0]      imem_addr,
    input  logic [2*frontend_pkg::xlen-1:0]    imem_rdata,
    output logic                               w_ena_1,
    output logic                               w_ena_2,
    output logic [frontend_pkg::entry_w-1:0]   w_entry_1,
    output logic [frontend_pkg::entry_w-1:0]   w_entry_2
);
    import frontend_pkg::*;

    logic [xlen-1:0] pc;
    logic            misaligned;  // pc[2] set, only the high word is fetched
    logic            fetch_on;    // low until the first edge after reset
    logic            fetch_go;
    logic [xlen-1:0] pc_hi;
    logic [xlen-1:0] lo_word;
    logic [xlen-1:0] hi_word;

    assign lo_word   = imem_rdata[xlen-1:0];
    assign hi_word   = imem_rdata[2*xlen-1:xlen];
    assign pc_hi     = pc + xlen'(4);

    assign imem_addr = {pc[xlen-1:3], 3'b000};  // 8-byte aligned pair

    assign fetch_go  = fetch_on & ~fetch_stall_req;
    assign w_ena_1   = fetch_go;
    assign w_ena_2   = fetch_go & ~misaligned;

    // a misaligned fetch sends the high word through slot 1
    assign w_entry_1 = misaligned ? {pc, hi_word} : {pc, lo_word};
    assign w_entry_2 = {pc_hi, hi_word};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= reset_pc;
            misaligned <= 1'b0;
            fetch_on   <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (redirect_valid) begin  // wins over a stall
                pc         <= redirect_pc;
                misaligned <= redirect_pc[2];
            end else if (fetch_go) begin
                pc         <= misaligned ? pc_hi : pc + xlen'(8);
                misaligned <= 1'b0;
            end
        end
    end

endmodule

//--- logic/frontend_pkg.sv
package frontend_pkg;

    localparam int xlen        = 32;
    localparam int entry_w     = 2 * xlen;  // pc high, inst low
    localparam int queue_depth = 8;         // stall timing needs at least 4
    localparam int queue_index = $clog2(queue_depth);

    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    // instruction fields
    localparam int op_w    = 7;
    localparam int reg_w   = 5;
    localparam int rd_lsb  = 7;
    localparam int rs1_lsb = 15;
    localparam int rs2_lsb = 20;

    // control-flow opcodes
    localparam logic [op_w-1:0] op_branch = 7'b110_0011;
    localparam logic [op_w-1:0] op_jal    = 7'b110_1111;
    localparam logic [op_w-1:0] op_jalr   = 7'b110_0111;

endpackage

//--- logic/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                               clk,
    input  logic                               arst_n,
    output logic [frontend_pkg::xlen-1:0]      imem_addr,
    input  logic [2*frontend_pkg::xlen-1:0]    imem_rdata,
    input  logic                               redirect_valid,
    input  logic [frontend_pkg::xlen-1:0]      redirect_pc,
    output logic                               issue_valid_0,
    output logic                               issue_valid_1,
    output logic [frontend_pkg::xlen-1:0]      issue_pc_0,
    output logic [frontend_pkg::xlen-1:0]      issue_pc_1,
    output logic [frontend_pkg::xlen-1:0]      issue_inst_0,
    output logic [frontend_pkg::xlen-1:0]      issue_inst_1,
    input  logic                               issue_ready
);
    import frontend_pkg::*;

    // fetch to queue
    logic               w_ena_1;
    logic               w_ena_2;
    logic [entry_w-1:0] w_entry_1;
    logic [entry_w-1:0] w_entry_2;
    logic               fetch_stall_req;

    // queue to issue
    logic [entry_w-1:0] head_1;
    logic [entry_w-1:0] head_2;
    logic               head_ok_1;
    logic               head_ok_2;
    logic               pop_1;
    logic               pop_2;

    fetch_pc i_fetch (
        .clk             (clk),
        .arst_n          (arst_n),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .fetch_stall_req (fetch_stall_req),
        .imem_addr       (imem_addr),
        .imem_rdata      (imem_rdata),
        .w_ena_1         (w_ena_1),
        .w_ena_2         (w_ena_2),
        .w_entry_1       (w_entry_1),
        .w_entry_2       (w_entry_2)
    );

    inst_queue i_queue (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (redirect_valid),  // branch resolution flush
        .w_ena_1         (w_ena_1),
        .w_ena_2         (w_ena_2),
        .w_entry_1       (w_entry_1),
        .w_entry_2       (w_entry_2),
        .pop_1           (pop_1),
        .pop_2           (pop_2),
        .head_1          (head_1),
        .head_2          (head_2),
        .head_ok_1       (head_ok_1),
        .head_ok_2       (head_ok_2),
        .fetch_stall_req (fetch_stall_req)
    );

    issue_pair i_issue (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (redirect_valid),
        .head_1          (head_1),
        .head_2          (head_2),
        .head_ok_1       (head_ok_1),
        .head_ok_2       (head_ok_2),
        .pop_1           (pop_1),
        .pop_2           (pop_2),
        .issue_valid_0   (issue_valid_0),
        .issue_valid_1   (issue_valid_1),
        .issue_pc_0      (issue_pc_0),
        .issue_pc_1      (issue_pc_1),
        .issue_inst_0    (issue_inst_0),
        .issue_inst_1    (issue_inst_1),
        .issue_ready     (issue_ready)
    );

endmodule

//--- logic/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               flush,
    input  logic                               w_ena_1,
    input  logic                               w_ena_2,
    input  logic [frontend_pkg::entry_w-1:0]   w_entry_1,
    input  logic [frontend_pkg::entry_w-1:0]   w_entry_2,
    input  logic                               pop_1,
    input  logic                               pop_2,
    output logic [frontend_pkg::entry_w-1:0]   head_1,
    output logic [frontend_pkg::entry_w-1:0]   head_2,
    output logic                               head_ok_1,
    output logic                               head_ok_2,
    output logic                               fetch_stall_req
);
    import frontend_pkg::*;

    typedef enum logic [1:0] {
        st_normal = 2'b00,
        st_wait_1 = 2'b01,
        st_wait_2 = 2'b10
    } state_t;

    state_t state;
    state_t state_nxt;

    logic [entry_w-1:0]   mem [queue_depth];
    logic [entry_w-1:0]   wait_1;
    logic [entry_w-1:0]   wait_2;
    logic [entry_w-1:0]   wait_1_nxt;
    logic [entry_w-1:0]   wait_2_nxt;

    // pointers carry one wrap bit above the index
    logic [queue_index:0] w_ptr;
    logic [queue_index:0] r_ptr;
    logic [queue_index:0] w_ptr_1;
    logic [queue_index:0] r_ptr_1;
    logic [queue_index:0] count;
    logic [queue_index:0] free;
    logic [queue_index:0] w_step;
    logic [queue_index:0] r_step;

    logic                 room_0;
    logic                 room_1;
    logic                 mem_we_1;
    logic                 mem_we_2;
    logic [entry_w-1:0]   mem_wd_1;
    logic [entry_w-1:0]   mem_wd_2;

    assign w_ptr_1 = w_ptr + (queue_index+1)'(1);
    assign r_ptr_1 = r_ptr + (queue_index+1)'(1);
    assign count   = w_ptr - r_ptr;
    assign free    = (queue_index+1)'(queue_depth) - count;
    assign room_0  = (free == '0);  // full
    assign room_1  = (free == (queue_index+1)'(1));

    assign head_1    = mem[r_ptr[queue_index-1:0]];
    assign head_2    = mem[r_ptr_1[queue_index-1:0]];
    assign head_ok_1 = (count != '0);
    assign head_ok_2 = (count[queue_index:1] != '0);  // two or more

    assign fetch_stall_req = room_0 | (state != st_normal);

    // pop_2 only counts together with pop_1
    always_comb begin
        r_step = '0;
        if (pop_1 && head_ok_1) begin
            r_step = (pop_2 && head_ok_2) ? (queue_index+1)'(2) : (queue_index+1)'(1);
        end
    end

    // append and wait-register parking, on pre-pop free space
    always_comb begin
        state_nxt  = state;
        w_step     = '0;
        mem_we_1   = 1'b0;
        mem_we_2   = 1'b0;
        mem_wd_1   = w_entry_1;
        mem_wd_2   = w_entry_2;
        wait_1_nxt = wait_1;
        wait_2_nxt = wait_2;
        case (state)
            st_normal: begin
                if (w_ena_1 && w_ena_2) begin
                    if (room_0) begin
                        wait_1_nxt = w_entry_1;
                        wait_2_nxt = w_entry_2;
                        state_nxt  = st_wait_2;
                    end else if (room_1) begin
                        mem_we_1   = 1'b1;
                        w_step     = (queue_index+1)'(1);
                        wait_1_nxt = w_entry_2;  // second one parks
                        state_nxt  = st_wait_1;
                    end else begin
                        mem_we_1 = 1'b1;
                        mem_we_2 = 1'b1;
                        w_step   = (queue_index+1)'(2);
                    end
                end else if (w_ena_1) begin
                    if (room_0) begin
                        wait_1_nxt = w_entry_1;
                        state_nxt  = st_wait_1;
                    end else begin
                        mem_we_1 = 1'b1;
                        w_step   = (queue_index+1)'(1);
                    end
                end
            end
            st_wait_1: begin
                mem_wd_1 = wait_1;
                if (!room_0) begin
                    mem_we_1  = 1'b1;
                    w_step    = (queue_index+1)'(1);
                    state_nxt = st_normal;
                end
            end
            st_wait_2: begin
                mem_wd_1 = wait_1;
                mem_wd_2 = wait_2;
                if (room_1) begin
                    mem_we_1   = 1'b1;
                    w_step     = (queue_index+1)'(1);
                    wait_1_nxt = wait_2;  // older one drains first
                    state_nxt  = st_wait_1;
                end else if (!room_0) begin
                    mem_we_1  = 1'b1;
                    mem_we_2  = 1'b1;
                    w_step    = (queue_index+1)'(2);
                    state_nxt = st_normal;
                end
            end
            default: begin
                state_nxt = st_normal;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_normal;
            w_ptr <= '0;
            r_ptr <= '0;
        end else if (flush) begin
            state <= st_normal;
            w_ptr <= '0;
            r_ptr <= '0;
        end else begin
            state <= state_nxt;
            w_ptr <= w_ptr + w_step;
            r_ptr <= r_ptr + r_step;
        end
    end

    always_ff @(posedge clk) begin
        wait_1 <= wait_1_nxt;
        wait_2 <= wait_2_nxt;
        if (mem_we_1) begin
            mem[w_ptr[queue_index-1:0]] <= mem_wd_1;
        end
        if (mem_we_2) begin
            mem[w_ptr_1[queue_index-1:0]] <= mem_wd_2;
        end
    end

endmodule

//--- logic/issue_pair.sv
`timescale 1ns/1ps

module issue_pair (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               flush,
    input  logic [frontend_pkg::entry_w-1:0]   head_1,
    input  logic [frontend_pkg::entry_w-1:0]   head_2,
    input  logic                               head_ok_1,
    input  logic                               head_ok_2,
    output logic                               pop_1,
    output logic                               pop_2,
    output logic                               issue_valid_0,
    output logic                               issue_valid_1,
    output logic [frontend_pkg::xlen-1:0]      issue_pc_0,
    output logic [frontend_pkg::xlen-1:0]      issue_pc_1,
    output logic [frontend_pkg::xlen-1:0]      issue_inst_0,
    output logic [frontend_pkg::xlen-1:0]      issue_inst_1,
    input  logic                               issue_ready
);
    import frontend_pkg::*;

    logic [entry_w-1:0] slot_0;
    logic [entry_w-1:0] slot_1;
    logic               valid_0;
    logic               valid_1;
    logic               load;

    logic [xlen-1:0]    inst_1;
    logic [xlen-1:0]    inst_2;
    logic [op_w-1:0]    op_1;
    logic [reg_w-1:0]   rd_1;
    logic [reg_w-1:0]   rs1_2;
    logic [reg_w-1:0]   rs2_2;
    logic               ctrl_1;
    logic               reg_clash;
    logic               pair_ok;

    assign inst_1 = head_1[xlen-1:0];
    assign inst_2 = head_2[xlen-1:0];
    assign op_1   = inst_1[op_w-1:0];
    assign rd_1   = inst_1[rd_lsb +: reg_w];
    assign rs1_2  = inst_2[rs1_lsb +: reg_w];
    assign rs2_2  = inst_2[rs2_lsb +: reg_w];

    assign ctrl_1 = (op_1 == op_branch) | (op_1 == op_jal) | (op_1 == op_jalr);

    // x0 as rd also blocks pairing
    assign reg_clash = (rd_1 == '0) | (rd_1 == rs1_2) | (rd_1 == rs2_2);
    assign pair_ok   = head_ok_2 & ~ctrl_1 & ~reg_clash;

    // free slot or contents leave this cycle
    assign load  = ~valid_0 | issue_ready;
    assign pop_1 = load & head_ok_1;
    assign pop_2 = pop_1 & pair_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_0 <= 1'b0;
            valid_1 <= 1'b0;
        end else if (flush) begin
            valid_0 <= 1'b0;
            valid_1 <= 1'b0;
        end else if (load) begin
            valid_0 <= head_ok_1;
            valid_1 <= pop_2;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_1) begin
            slot_0 <= head_1;
        end
        if (pop_2) begin
            slot_1 <= head_2;
        end
    end

    assign issue_valid_0 = valid_0;
    assign issue_valid_1 = valid_1;
    assign issue_pc_0    = slot_0[entry_w-1:xlen];
    assign issue_pc_1    = slot_1[entry_w-1:xlen];
    assign issue_inst_0  = slot_0[xlen-1:0];
    assign issue_inst_1  = slot_1[xlen-1:0];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module frontend_tb -f all.f --Mdir obj_dir -o frontend_sim
./obj_dir/frontend_sim 2>&1 | tee sim.log
grep -q "^TESTS PASSED$" sim.log
echo "simulation passed"

//--- testbench/frontend_asserts.sv
`timescale 1ns/1ps

module frontend_asserts (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               flush,
    input  logic                               w_ena_1,
    input  logic                               w_ena_2,
    input  logic                               pop_1,
    input  logic                               pop_2,
    input  logic [frontend_pkg::queue_index:0] w_ptr,
    input  logic [frontend_pkg::queue_index:0] r_ptr,
    input  logic [frontend_pkg::queue_index:0] count,
    input  logic                               head_ok_1,
    input  logic                               head_ok_2,
    input  logic                               fetch_stall_req
);
    import frontend_pkg::*;

    int fail_count = 0;

    // fetch must also stop writing while the queue is full
    full_stalls: assert property (@(posedge clk) disable iff (!arst_n)
        (count == (queue_index+1)'(queue_depth)) |->
            (fetch_stall_req && !w_ena_1 && !w_ena_2))
    else begin
        fail_count++;
        $error("queue full without a stall request or with a write");
    end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> ((w_ptr == '0) && (r_ptr == '0)))
    else begin
        fail_count++;
        $error("queue pointers not cleared after a flush");
    end

    head_order: assert property (@(posedge clk) disable iff (!arst_n)
        (head_ok_2 || pop_2) |-> (head_ok_1 && (!pop_2 || (pop_1 && head_ok_2))))
    else begin
        fail_count++;
        $error("second head valid or popped without the first");
    end

endmodule

bind inst_queue frontend_asserts i_asserts (
    .clk             (clk),
    .arst_n          (arst_n),
    .flush           (flush),
    .w_ena_1         (w_ena_1),
    .w_ena_2         (w_ena_2),
    .pop_1           (pop_1),
    .pop_2           (pop_2),
    .w_ptr           (w_ptr),
    .r_ptr           (r_ptr),
    .count           (count),
    .head_ok_1       (head_ok_1),
    .head_ok_2       (head_ok_2),
    .fetch_stall_req (fetch_stall_req)
);

//--- testbench/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;
    import frontend_pkg::*;

    logic               clk;
    logic               arst_n;
    logic [xlen-1:0]    imem_addr;
    logic [2*xlen-1:0]  imem_rdata;
    logic               redirect_valid;
    logic [xlen-1:0]    redirect_pc;
    logic               issue_valid_0;
    logic               issue_valid_1;
    logic [xlen-1:0]    issue_pc_0;
    logic [xlen-1:0]    issue_pc_1;
    logic [xlen-1:0]    issue_inst_0;
    logic [xlen-1:0]    issue_inst_1;
    logic               issue_ready;

    logic [xlen-1:0]    prog [1024];  // 4 KiB from reset_pc
    logic [15:0]        lfsr_state;
    logic [xlen-1:0]    exp_pc = reset_pc;
    logic               single_next = 1'b0;  // entry after a misaligned redirect
    int                 mon_errors = 0;
    int                 test_errors = 0;
    int                 issued_count = 0;
    int                 transfers = 0;
    int                 pairs = 0;
    int                 wait_cycles = 0;

    tb_clock i_clock (.clk(clk), .arst_n(arst_n));

    frontend_top i_dut (.*);

    function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
        logic [xlen-1:0] offset;
        offset = addr - reset_pc;
        if (offset < 32'd4096) begin
            return prog[offset[11:2]];
        end
        return {addr[31:7] ^ addr[24:0], 7'h13};  // outside the program
    endfunction

    always_comb begin
        imem_rdata = {word_at(imem_addr + 32'd4), word_at(imem_addr)};
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | {31'b0, lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // mixed = 0 gives ALU ops with rd x1 reading x2 and x3, always pairable
    task automatic fill_program(input logic mixed);
        logic [31:0]     r;
        logic [xlen-1:0] w;
        for (int i = 0; i < 1024; i++) begin
            w = '0;
            if (!mixed) begin
                take_bits(10, r);
                w[6:0] = 7'h13;
                w[rd_lsb +: 5] = 5'd1;
                w[rs1_lsb +: 5] = 5'd2;
                w[rs2_lsb +: 5] = 5'd3;
                w[14:12] = r[2:0];
                w[31:25] = r[9:3];
            end else begin
                take_bits(3, r);
                case (r[2:0])
                    3'd0, 3'd1: w[6:0] = 7'h13;
                    3'd2, 3'd3: w[6:0] = 7'h33;
                    3'd4:       w[6:0] = op_branch;
                    3'd5:       w[6:0] = op_jal;
                    3'd6:       w[6:0] = op_jalr;
                    default:    w[6:0] = 7'h03;
                endcase
                take_bits(2, r);
                w[rd_lsb +: 5] = r[4:0];  // x0..x3 for frequent hazards
                take_bits(2, r);
                w[rs1_lsb +: 5] = r[4:0];
                take_bits(2, r);
                w[rs2_lsb +: 5] = r[4:0];
                take_bits(3, r);
                w[14:12] = r[2:0];
            end
            prog[10'(i)] = w;
        end
    endtask

    function automatic logic may_pair(input logic [xlen-1:0] first, input logic [xlen-1:0] second);
        logic [4:0] rd;
        logic       ctrl;
        rd   = first[rd_lsb +: 5];
        ctrl = (first[6:0] == op_branch) || (first[6:0] == op_jal) || (first[6:0] == op_jalr);
        return !ctrl && (rd != 5'd0) && (rd != second[rs1_lsb +: 5])
            && (rd != second[rs2_lsb +: 5]);
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want, inout int count);
        count++;
        $display("[ERROR] %s = 0x%h, expected 0x%h", name, got, want);
    endtask

    task automatic flag_failure(input string what, inout int count);
        count++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // in-order model of the issue stream, checked on every transfer
    always @(negedge clk) begin : monitor
        logic [xlen-1:0] w0;
        logic [xlen-1:0] w1;
        logic            want_pair;
        if (arst_n) begin
            if (i_dut.i_queue.state != 2'b00) begin
                wait_cycles++;
            end
            assert (issue_valid_0 || !issue_valid_1)
                else flag_failure("issue_valid_1 high without issue_valid_0", mon_errors);
            if (issue_valid_0 && issue_ready) begin
                w0 = word_at(exp_pc);
                w1 = word_at(exp_pc + 32'd4);
                want_pair = !single_next && may_pair(w0, w1);
                assert (issue_pc_0 == exp_pc)
                    else flag_mismatch("issue_pc_0", issue_pc_0, exp_pc, mon_errors);
                assert (issue_inst_0 == w0)
                    else flag_mismatch("issue_inst_0", issue_inst_0, w0, mon_errors);
                assert (issue_valid_1 == want_pair)
                    else flag_mismatch("issue_valid_1", 32'(issue_valid_1), 32'(want_pair),
                                       mon_errors);
                if (want_pair && issue_valid_1) begin
                    assert (issue_pc_1 == exp_pc + 32'd4)
                        else flag_mismatch("issue_pc_1", issue_pc_1, exp_pc + 32'd4, mon_errors);
                    assert (issue_inst_1 == w1)
                        else flag_mismatch("issue_inst_1", issue_inst_1, w1, mon_errors);
                end
                transfers++;
                pairs += issue_valid_1 ? 1 : 0;
                issued_count += want_pair ? 2 : 1;
                exp_pc = exp_pc + (want_pair ? 32'd8 : 32'd4);
                single_next = 1'b0;
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;
                single_next = redirect_pc[2];  // high word arrives alone
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_issued(input int more, input int limit);
        int target;
        int cycles;
        target = issued_count + more;
        cycles = 0;
        while (issued_count < target && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (issued_count < target) begin
            $display("timeout: %0d entries issued, waiting for %0d", issued_count, target);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic wait_valid(input int limit);
        int cycles;
        cycles = 0;
        while (!issue_valid_0 && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!issue_valid_0) begin
            $display("timeout: issue_valid_0 never rose after the redirect");
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic pulse_redirect(input logic [xlen-1:0] target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    task automatic check_reset();
        int cycles;
        cycles = 0;
        @(negedge clk);
        assert (imem_addr == reset_pc)
            else flag_mismatch("imem_addr", imem_addr, reset_pc, test_errors);
        assert (!issue_valid_0 && !issue_valid_1)
            else flag_failure("issue valid high during reset", test_errors);
        assert (!i_dut.fetch_stall_req && !i_dut.w_ena_1 && !i_dut.w_ena_2)
            else flag_failure("queue write or stall active during reset", test_errors);
        while (!arst_n && cycles < 10) begin
            next_cycle();
            cycles++;
        end
        if (!arst_n) begin
            $display("timeout: reset never released");
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic straight_line_test();
        int t0;
        int p0;
        issue_ready = 1'b1;
        t0 = transfers;
        p0 = pairs;
        wait_issued(64, 200);
        assert ((pairs - p0) == (transfers - t0))
            else flag_failure("straight-line stream issued a single entry", test_errors);
    endtask

    task automatic pairing_test();
        int t0;
        int p0;
        next_cycle();
        issue_ready = 1'b0;
        fill_program(1'b1);
        pulse_redirect(reset_pc);
        issue_ready = 1'b1;
        t0 = transfers;
        p0 = pairs;
        wait_issued(200, 400);
        assert ((pairs - p0) > 0 && (transfers - t0) > (pairs - p0))
            else flag_failure("pairing stream lacked a mix of pairs and singles", test_errors);
    endtask

    task automatic backpressure_test();
        logic [31:0] r;
        int          w0;
        w0 = wait_cycles;
        issue_ready = 1'b0;
        repeat (30) next_cycle();
        for (int i = 0; i < 300; i++) begin
            take_bits(1, r);
            issue_ready = r[0];
            next_cycle();
        end
        issue_ready = 1'b1;
        wait_issued(16, 40);
        assert (wait_cycles > w0)
            else flag_failure("wait registers never held data under back-pressure", test_errors);
    endtask

    task automatic redirect_test(input logic [xlen-1:0] target);
        repeat (5) next_cycle();
        pulse_redirect(target);
        wait_valid(10);
        assert (issue_pc_0 == target)
            else flag_mismatch("issue_pc_0", issue_pc_0, target, test_errors);
        if (target[2]) begin
            assert (!issue_valid_1)
                else flag_failure("misaligned target issued with a partner", test_errors);
            next_cycle();
            wait_valid(10);
            assert (issue_pc_0 == target + 32'd4)
                else flag_mismatch("issue_pc_0", issue_pc_0, target + 32'd4, test_errors);
        end
        wait_issued(20, 60);
    endtask

    initial begin
        int total;
        issue_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        lfsr_state     = 16'd21;
        fill_program(1'b0);
        check_reset();
        straight_line_test();
        pairing_test();
        backpressure_test();
        redirect_test(reset_pc + 32'h400);
        redirect_test(reset_pc + 32'h804);
        repeat (4) next_cycle();
        total = mon_errors + test_errors + i_dut.i_queue.i_asserts.fail_count;
        $display("errors: %0d, transfers: %0d, pairs: %0d", total, transfers, pairs);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;  // released just after the fourth edge
    end

endmodule
